// ==== src/cuPkg.sv ====
`default_nettype none

package cuPkg;

    localparam int addrBits = 8;
    localparam int wordBits = 43;

    typedef logic [31:0]         instrT;
    typedef logic [addrBits-1:0] stateAddrT;
    typedef logic [wordBits-1:0] microWordT;
    typedef logic [3:0]          aluOpT;     // CUOp field
    typedef logic [1:0]          muxSel2T;   // m, MA, MC and ALU-B select

    typedef enum logic [2:0] {
        nsEncoder   = 3'd0,  // Decoder output
        nsDirect1   = 3'd1,  // Back to fetch
        nsCtrlReg   = 3'd2,  // Jump field CR
        nsIncrement = 3'd3,
        nsStsCrEnc  = 3'd4,
        nsStsCrInc  = 3'd5,
        nsStsEncInc = 3'd6,
        nsStsCrDir1 = 3'd7
    } nextSelT;

    typedef enum logic [1:0] {
        stsLow  = 2'd0,
        stsCond = 2'd1,  // Condition passed
        stsMoc  = 2'd2,  // Memory operation complete
        stsHigh = 2'd3
    } statusSelT;

    typedef enum logic [1:0] {
        srcEncoder   = 2'd0,
        srcDirect1   = 2'd1,
        srcCtrlReg   = 2'd2,
        srcIncrement = 2'd3
    } addrSrcT;

    localparam stateAddrT stReset       = 8'd0;
    localparam stateAddrT stFetch       = 8'd1;   // First fetch state
    localparam stateAddrT stCond        = 8'd4;
    localparam stateAddrT stLogAriReg   = 8'd5;
    localparam stateAddrT stLogAriShift = 8'd6;
    localparam stateAddrT stLogAriImm   = 8'd7;
    localparam stateAddrT stTestReg     = 8'd8;
    localparam stateAddrT stTestShift   = 8'd9;
    localparam stateAddrT stTestImm     = 8'd10;
    localparam stateAddrT stMovReg      = 8'd11;
    localparam stateAddrT stMovShift    = 8'd12;
    localparam stateAddrT stMovImm      = 8'd13;
    localparam stateAddrT stBranch      = 8'd14;
    localparam stateAddrT stBranchLink  = 8'd15;
    localparam stateAddrT maxStateAddr  = 8'd16;  // Highest address held in the microstore

    // Microword field positions from N at the top
    localparam int posNextHi   = 42;
    localparam int posNextLo   = 40;
    localparam int posInv      = 39;
    localparam int posStsHi    = 38;
    localparam int posStsLo    = 37;
    localparam int posCrHi     = 36;
    localparam int posCrLo     = 29;
    localparam int posRfLoad   = 28;
    localparam int posIrLoad   = 27;
    localparam int posMarLoad  = 26;
    localparam int posMdrLoad  = 25;
    localparam int posRw       = 24;
    localparam int posMov      = 23;   // Bit 22 is spare
    localparam int posMuxMHi   = 21;
    localparam int posMuxMLo   = 20;
    localparam int posMuxAHi   = 19;
    localparam int posMuxALo   = 18;
    localparam int posMuxB     = 17;
    localparam int posMuxCHi   = 16;
    localparam int posMuxCLo   = 15;
    localparam int posAluASel  = 14;
    localparam int posAluBHi   = 13;
    localparam int posAluBLo   = 12;
    localparam int posMuxD     = 11;
    localparam int posMuxE     = 10;
    localparam int posAluOpHi  = 9;
    localparam int posAluOpLo  = 6;
    localparam int posMarClr   = 5;
    localparam int posMdrClr   = 4;
    localparam int posIrClr    = 3;
    localparam int posSrLoad   = 2;
    localparam int posSrClr    = 1;
    localparam int posCondEn   = 0;

    // State 0 with fields grouped as N_Inv_S_CR_loads_muxes_CUOp_clears
    localparam microWordT resetWord =
        43'b011_0_00_00000000_1000000_000000101110_1101_000000;

endpackage

`default_nettype wire

// ==== src/instrDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instrDecoder import cuPkg::*; (
    input  wire instrT Instr,
    output stateAddrT  decodedAddr
);

    logic [2:0] instrClass;  // Bits 27:25
    logic       regShift;    // Shift amount from a register
    logic       isTest;      // TST, TEQ, CMP, CMN
    logic       isMove;      // MOV opcode
    logic       linkBit;     // Branch with link

    assign instrClass = Instr[27:25];
    assign regShift   = Instr[4];
    assign isTest     = (Instr[24:23] == 2'b10);
    assign isMove     = (Instr[24:21] == 4'b1101);
    assign linkBit    = Instr[24];

    always_comb begin
        decodedAddr = stReset;
        case (instrClass)
            3'b000: begin  // Data processing with shifted register
                if (isTest) begin
                    decodedAddr = regShift ? stTestReg : stTestShift;
                end else if (isMove) begin
                    decodedAddr = regShift ? stMovReg : stMovShift;
                end else begin
                    decodedAddr = regShift ? stLogAriReg : stLogAriShift;
                end
            end
            3'b001: begin  // Data processing immediate
                if (isTest) begin
                    decodedAddr = stTestImm;
                end else if (isMove) begin
                    decodedAddr = stMovImm;
                end else begin
                    decodedAddr = stLogAriImm;
                end
            end
            3'b101: begin
                decodedAddr = linkBit ? stBranchLink : stBranch;
            end
            default: begin
                decodedAddr = stReset;  // Load/store and undefined classes
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/nextAddressLogic.sv ====
`timescale 1ns/100ps
`default_nettype none

module nextAddressLogic import cuPkg::*; (
    input  wire logic      CLK,
    input  wire logic      CLR,
    input  wire nextSelT   NextSel,
    input  wire logic      Inv,
    input  wire statusSelT StatusSel,
    input  wire stateAddrT JumpAddr,
    input  wire stateAddrT decodedAddr,
    input  wire logic      CondPass,
    input  wire logic      Moc,
    output stateAddrT      nextAddr
);

    logic      stsRaw;    // Status before inversion
    logic      sts;
    addrSrcT   addrSrc;
    stateAddrT incrAddr;  // Incrementer register

    always_comb begin
        case (StatusSel)
            stsLow:  stsRaw = 1'b0;
            stsCond: stsRaw = CondPass;
            stsMoc:  stsRaw = Moc;
            default: stsRaw = 1'b1;  // stsHigh
        endcase
    end

    assign sts = stsRaw ^ Inv;

    // Next-state selector
    always_comb begin
        case (NextSel)
            nsEncoder:   addrSrc = srcEncoder;
            nsDirect1:   addrSrc = srcDirect1;
            nsCtrlReg:   addrSrc = srcCtrlReg;
            nsIncrement: addrSrc = srcIncrement;
            nsStsCrEnc:  addrSrc = sts ? srcCtrlReg : srcEncoder;
            nsStsCrInc:  addrSrc = sts ? srcCtrlReg : srcIncrement;
            nsStsEncInc: addrSrc = sts ? srcEncoder : srcIncrement;
            default:     addrSrc = sts ? srcCtrlReg : srcDirect1;  // nsStsCrDir1
        endcase
    end

    always_comb begin
        case (addrSrc)
            srcEncoder: nextAddr = decodedAddr;
            srcDirect1: nextAddr = stFetch;
            srcCtrlReg: nextAddr = JumpAddr;
            default:    nextAddr = incrAddr;
        endcase
    end

    // Holds the address after the one being loaded this cycle
    always_ff @(posedge CLK or negedge CLR) begin
        if (!CLR) begin
            incrAddr <= stFetch;
        end else begin
            incrAddr <= nextAddr + 8'd1;
        end
    end

    // Decoder, jump fields and incrementer together never leave the stored table
    nextAddrInRange: assert property (
        @(posedge CLK) disable iff (!CLR) nextAddr <= maxStateAddr
    ) else $error("nextAddr %0d is beyond the microstore", nextAddr);

endmodule

`default_nettype wire

// ==== src/microstore.sv ====
`timescale 1ns/100ps
`default_nettype none

module microstore import cuPkg::*; (
    input  wire stateAddrT Addr,
    output microWordT      Word
);

    // Fields grouped as N_Inv_S_CR_loads_muxes_CUOp_clears
    always_comb begin
        case (Addr)
            stReset: Word = resetWord;
            stFetch: Word = 43'b011_0_00_00000000_0010000_000010000010_1101_000000;  // MAR <- PC
            8'd2:    Word = 43'b011_0_00_00000000_1000110_100010110010_0100_000000;  // Read, PC+4
            // Loads IR and stays here until Moc
            8'd3:    Word = 43'b101_1_10_00000011_0100110_100000000000_0000_000000;
            // Back to fetch on a failed condition, else decode
            stCond:  Word = 43'b100_1_01_00000001_0000000_000000000000_0000_000000;
            stLogAriReg, stMovReg:
                Word = 43'b010_0_00_00000001_1000000_000000000000_0000_000001;
            stLogAriShift, stLogAriImm, stMovShift, stMovImm:
                Word = 43'b010_0_00_00000001_1000000_000000000100_0000_000001;
            stTestReg:
                Word = 43'b010_0_00_00000001_0000000_000000000000_0000_000101;  // Flags only
            stTestShift, stTestImm:
                Word = 43'b010_0_00_00000001_0000000_000000000100_0000_000101;
            stBranch:
                Word = 43'b010_0_00_00000001_1000000_000010110110_0100_000001;
            stBranchLink:
                Word = 43'b011_0_00_00000000_1000000_000011100010_1101_000001;  // Save LR
            8'd16:
                Word = 43'b010_0_00_00000001_1000000_000010110110_0100_000000;  // Link branch
            default: Word = resetWord;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/microRegister.sv ====
`timescale 1ns/100ps
`default_nettype none

module microRegister import cuPkg::*; (
    input  wire logic      CLK,
    input  wire logic      CLR,
    input  wire microWordT Word,
    input  wire stateAddrT Addr,
    output nextSelT        NextSel,
    output logic           Inv,
    output statusSelT      StatusSel,
    output stateAddrT      JumpAddr,
    output logic           RfLoad,
    output logic           IrLoad,
    output logic           MarLoad,
    output logic           MdrLoad,
    output logic           Rw,
    output logic           Mov,
    output muxSel2T        MuxA,
    output logic           MuxB,
    output muxSel2T        MuxC,
    output muxSel2T        MuxM,
    output logic           AluASel,
    output muxSel2T        AluBSel,
    output logic           MuxD,
    output logic           MuxE,
    output aluOpT          AluOp,
    output logic           MarClr,
    output logic           MdrClr,
    output logic           IrClr,
    output logic           SrLoad,
    output logic           SrClr,
    output logic           CondEn,
    output stateAddrT      StateAddr
);

    microWordT wordQ;  // Current microword

    always_ff @(posedge CLK or negedge CLR) begin
        if (!CLR) begin
            wordQ     <= resetWord;
            StateAddr <= stReset;
        end else begin
            wordQ     <= Word;
            StateAddr <= Addr;
        end
    end

    assign NextSel   = nextSelT'(wordQ[posNextHi:posNextLo]);
    assign Inv       = wordQ[posInv];
    assign StatusSel = statusSelT'(wordQ[posStsHi:posStsLo]);
    assign JumpAddr  = wordQ[posCrHi:posCrLo];

    assign RfLoad  = wordQ[posRfLoad];
    assign IrLoad  = wordQ[posIrLoad];
    assign MarLoad = wordQ[posMarLoad];
    assign MdrLoad = wordQ[posMdrLoad];
    assign Rw      = wordQ[posRw];
    assign Mov     = wordQ[posMov];   // Held through a Moc wait
    assign MuxM    = wordQ[posMuxMHi:posMuxMLo];
    assign MuxA    = wordQ[posMuxAHi:posMuxALo];
    assign MuxB    = wordQ[posMuxB];
    assign MuxC    = wordQ[posMuxCHi:posMuxCLo];
    assign AluASel = wordQ[posAluASel];
    assign AluBSel = wordQ[posAluBHi:posAluBLo];
    assign MuxD    = wordQ[posMuxD];
    assign MuxE    = wordQ[posMuxE];
    assign AluOp   = wordQ[posAluOpHi:posAluOpLo];
    assign MarClr  = wordQ[posMarClr];
    assign MdrClr  = wordQ[posMdrClr];
    assign IrClr   = wordQ[posIrClr];
    assign SrLoad  = wordQ[posSrLoad];
    assign SrClr   = wordQ[posSrClr];
    assign CondEn  = wordQ[posCondEn];

    // Instruction, status inputs and table must together keep the state defined
    stateAddrKnown: assert property (
        @(posedge CLK) disable iff (!CLR) !$isunknown(StateAddr)
    ) else $error("StateAddr is unknown");

endmodule

`default_nettype wire

// ==== src/controlUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module controlUnit import cuPkg::*; (
    input  wire logic  CLK,
    input  wire logic  CLR,
    input  wire instrT Instr,
    input  wire logic  CondPass,
    input  wire logic  Moc,
    output logic       RfLoad,
    output logic       IrLoad,
    output logic       MarLoad,
    output logic       MdrLoad,
    output logic       Rw,
    output logic       Mov,
    output muxSel2T    MuxA,
    output logic       MuxB,
    output muxSel2T    MuxC,
    output muxSel2T    MuxM,
    output logic       AluASel,
    output muxSel2T    AluBSel,
    output logic       MuxD,
    output logic       MuxE,
    output aluOpT      AluOp,
    output logic       MarClr,
    output logic       MdrClr,
    output logic       IrClr,
    output logic       SrLoad,
    output logic       SrClr,
    output logic       CondEn,
    output stateAddrT  StateAddr
);

    stateAddrT decodedAddr;
    stateAddrT nextAddr;
    microWordT nextWord;   // Word for nextAddr, loaded on the edge
    nextSelT   nextSel;
    logic      inv;
    statusSelT statusSel;
    stateAddrT jumpAddr;

    instrDecoder decoder (
        .Instr       (Instr),
        .decodedAddr (decodedAddr)
    );

    nextAddressLogic addrLogic (
        .CLK         (CLK),
        .CLR         (CLR),
        .NextSel     (nextSel),
        .Inv         (inv),
        .StatusSel   (statusSel),
        .JumpAddr    (jumpAddr),
        .decodedAddr (decodedAddr),
        .CondPass    (CondPass),
        .Moc         (Moc),
        .nextAddr    (nextAddr)
    );

    microstore store (
        .Addr (nextAddr),
        .Word (nextWord)
    );

    microRegister wordReg (
        .CLK       (CLK),
        .CLR       (CLR),
        .Word      (nextWord),
        .Addr      (nextAddr),
        .NextSel   (nextSel),
        .Inv       (inv),
        .StatusSel (statusSel),
        .JumpAddr  (jumpAddr),
        .RfLoad    (RfLoad),
        .IrLoad    (IrLoad),
        .MarLoad   (MarLoad),
        .MdrLoad   (MdrLoad),
        .Rw        (Rw),
        .Mov       (Mov),
        .MuxA      (MuxA),
        .MuxB      (MuxB),
        .MuxC      (MuxC),
        .MuxM      (MuxM),
        .AluASel   (AluASel),
        .AluBSel   (AluBSel),
        .MuxD      (MuxD),
        .MuxE      (MuxE),
        .AluOp     (AluOp),
        .MarClr    (MarClr),
        .MdrClr    (MdrClr),
        .IrClr     (IrClr),
        .SrLoad    (SrLoad),
        .SrClr     (SrClr),
        .CondEn    (CondEn),
        .StateAddr (StateAddr)
    );

endmodule

`default_nettype wire

// ==== include/cuModel.svh ====
`ifndef CU_MODEL_SVH
`define CU_MODEL_SVH

// Reference microstore with fields grouped as N_Inv_S_CR_loads_muxes_CUOp_clears
function automatic logic [42:0] modelWord(input logic [7:0] addr);
    case (addr)
        8'd1:  return 43'b011_0_00_00000000_0010000_000010000010_1101_000000;
        8'd2:  return 43'b011_0_00_00000000_1000110_100010110010_0100_000000;
        8'd3:  return 43'b101_1_10_00000011_0100110_100000000000_0000_000000;  // Moc wait
        8'd4:  return 43'b100_1_01_00000001_0000000_000000000000_0000_000000;  // Condition
        8'd5, 8'd11:
            return 43'b010_0_00_00000001_1000000_000000000000_0000_000001;
        8'd6, 8'd7, 8'd12, 8'd13:
            return 43'b010_0_00_00000001_1000000_000000000100_0000_000001;
        8'd8:  return 43'b010_0_00_00000001_0000000_000000000000_0000_000101;
        8'd9, 8'd10:
            return 43'b010_0_00_00000001_0000000_000000000100_0000_000101;
        8'd14: return 43'b010_0_00_00000001_1000000_000010110110_0100_000001;
        8'd15: return 43'b011_0_00_00000000_1000000_000011100010_1101_000001;
        8'd16: return 43'b010_0_00_00000001_1000000_000010110110_0100_000000;
        default: return 43'b011_0_00_00000000_1000000_000000101110_1101_000000;  // State 0
    endcase
endfunction

// Routine start for an instruction with kinds in groups of three forms
function automatic logic [7:0] expectedStart(input logic [31:0] instr);
    logic [7:0] kindBase;
    if (instr[24:23] == 2'b10) begin
        kindBase = 8'd8;   // Test and compare
    end else if (instr[24:21] == 4'b1101) begin
        kindBase = 8'd11;  // Move
    end else begin
        kindBase = 8'd5;
    end
    case (instr[27:25])
        3'b000:  return instr[4] ? kindBase : kindBase + 8'd1;
        3'b001:  return kindBase + 8'd2;
        3'b101:  return instr[24] ? 8'd15 : 8'd14;
        default: return 8'd0;
    endcase
endfunction

// Next state from the N, S and Inv fields of the current word
function automatic logic [7:0] nextStateRef(input logic [42:0] word, input logic [7:0] incr,
                                            input logic [31:0] instr, input logic condPass,
                                            input logic moc);
    logic       status;
    logic [7:0] jump;
    logic [7:0] enc;
    jump = word[36:29];
    enc  = expectedStart(instr);
    case (word[38:37])
        2'd0:    status = 1'b0;
        2'd1:    status = condPass;
        2'd2:    status = moc;
        default: status = 1'b1;
    endcase
    status = status ^ word[39];
    case (word[42:40])
        3'd0:    return enc;
        3'd1:    return 8'd1;
        3'd2:    return jump;
        3'd3:    return incr;
        3'd4:    return status ? jump : enc;
        3'd5:    return status ? jump : incr;
        3'd6:    return status ? enc : incr;
        default: return status ? jump : 8'd1;
    endcase
endfunction

`endif

// ==== tests/controlUnitTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module controlUnitTb;

    localparam int clkPeriod      = 4;
    localparam int resetCycles    = 8;
    localparam int numDirected    = 17;
    localparam int numRandom      = 200;
    localparam int cyclesPerInstr = 40;
    localparam int timeoutNs = (resetCycles + (numDirected + numRandom) * cyclesPerInstr)
                               * clkPeriod;

    logic        CLK;
    logic        CLR;
    logic [31:0] Instr;
    logic        CondPass;
    logic        Moc;
    logic        RfLoad, IrLoad, MarLoad, MdrLoad, Rw, Mov;
    logic [1:0]  MuxA, MuxC, MuxM, AluBSel;
    logic        MuxB, AluASel, MuxD, MuxE;
    logic [3:0]  AluOp;
    logic        MarClr, MdrClr, IrClr, SrLoad, SrClr, CondEn;
    logic [7:0]  StateAddr;

    logic [27:0] dutControls;  // Same order as the word minus sequencing fields
    logic [7:0]  expState;
    logic [7:0]  expIncr;
    logic [42:0] expWord;
    bit          modelValid = 1'b0;
    int          seed;

    `include "cuModel.svh"

    controlUnit dut (.*);

    assign dutControls = {RfLoad, IrLoad, MarLoad, MdrLoad, Rw, Mov, MuxM, MuxA, MuxB, MuxC,
                          AluASel, AluBSel, MuxD, MuxE, AluOp,
                          MarClr, MdrClr, IrClr, SrLoad, SrClr, CondEn};

    initial begin
        CLK = 1'b0;
        forever #(clkPeriod / 2) CLK = ~CLK;
    end

    task automatic checkValue(input string testName, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", testName, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic waitDriveSlot();
        @(posedge CLK);
        #1;
    endtask

    // Model steps on the same edge as the DUT while the inputs are stable
    always @(posedge CLK) begin : modelStep
        logic [7:0] predicted;
        if (!CLR) begin
            expState = 8'd0;
            expIncr  = 8'd1;
        end else begin
            predicted = nextStateRef(modelWord(expState), expIncr, Instr, CondPass, Moc);
            expState  = predicted;
            expIncr   = predicted + 8'd1;
        end
        modelValid = 1'b1;
    end

    always @(negedge CLK) begin
        if (modelValid) begin
            expWord = modelWord(expState);
            checkValue($sformatf("state address after state %0d", expState),
                       64'(expState), 64'(StateAddr));
            checkValue($sformatf("controls in state %0d", expState),
                       64'({expWord[28:23], expWord[21:0]}), 64'(dutControls));
        end
    end

    // One pass through fetch, the Moc wait and the condition state
    task automatic runInstr(input string name, input logic [31:0] instr, input logic cond,
                            input int mocDelay);
        logic [7:0] expAfterCond;
        expAfterCond = cond ? expectedStart(instr) : 8'd1;
        while (StateAddr !== 8'd3) begin
            waitDriveSlot();
        end
        Instr    = instr;
        CondPass = cond;
        Moc      = 1'b0;
        repeat (mocDelay) begin
            waitDriveSlot();
            checkValue($sformatf("%s held in wait", name), 64'd3, 64'(StateAddr));
            checkValue($sformatf("%s MOV in wait", name), 64'd1, 64'(Mov));
        end
        Moc = 1'b1;
        waitDriveSlot();
        checkValue($sformatf("%s condition state", name), 64'd4, 64'(StateAddr));
        Moc = 1'b0;
        waitDriveSlot();
        checkValue($sformatf("%s routine start", name), 64'(expAfterCond), 64'(StateAddr));
    endtask

    function automatic logic [31:0] buildDataProc(input logic [2:0] cls, input logic [3:0] op,
                                                  input logic regShift);
        return {4'hE, cls, op, 1'b1, 4'h1, 4'h2, 7'h00, regShift, 4'h3};
    endfunction

    initial begin : stimulus
        logic [3:0]  kindOps [3];
        logic [31:0] randWord;
        logic [31:0] randInstr;
        logic [2:0]  cls;
        int          mocDelay;
        kindOps  = '{4'b0100, 4'b1010, 4'b1101};  // ADD, CMP, MOV
        seed     = 85;
        CLR      = 1'b0;
        Instr    = 32'h0;
        CondPass = 1'b0;
        Moc      = 1'b0;
        repeat (resetCycles) @(posedge CLK);
        #1;
        checkValue("state during reset", 64'd0, 64'(StateAddr));
        CLR = 1'b1;

        for (int k = 0; k < 3; k++) begin
            for (int form = 0; form < 3; form++) begin
                cls      = (form == 2) ? 3'b001 : 3'b000;
                mocDelay = $unsigned($random(seed)) % 6;
                runInstr($sformatf("op %b form %0d", kindOps[k], form),
                         buildDataProc(cls, kindOps[k], form == 0), 1'b1, mocDelay);
            end
        end
        runInstr("failed condition", buildDataProc(3'b000, 4'b0100, 1'b1), 1'b0, 2);
        runInstr("branch", {4'hE, 3'b101, 1'b0, 24'h000010}, 1'b1, 1);
        runInstr("branch with link", {4'hE, 3'b101, 1'b1, 24'h000010}, 1'b1, 3);
        runInstr("load/store immediate", {4'hE, 3'b010, 25'h0000010}, 1'b1, 0);
        runInstr("load/store register", {4'hE, 3'b011, 25'h0000010}, 1'b1, 4);
        runInstr("block transfer", {4'hE, 3'b100, 25'h0000010}, 1'b1, 5);
        runInstr("coprocessor", {4'hE, 3'b110, 25'h0000010}, 1'b1, 1);
        runInstr("software interrupt", {4'hE, 3'b111, 25'h0000010}, 1'b1, 2);

        for (int i = 0; i < numRandom; i++) begin
            randInstr = $random(seed);
            randWord  = $random(seed);
            mocDelay  = $unsigned($random(seed)) % 6;
            runInstr($sformatf("random %0d", i), randInstr, randWord[1:0] != 2'b00, mocDelay);
        end

        // Last routine has to come back to the fetch wait
        while (StateAddr !== 8'd3) begin
            waitDriveSlot();
        end
        repeat (2) waitDriveSlot();
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("Timeout: the run did not finish within %0d ns", timeoutNs);
        $display("CHECKS FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

// ==== controlUnit.f ====
+incdir+include
src/cuPkg.sv
src/instrDecoder.sv
src/nextAddressLogic.sv
src/microstore.sv
src/microRegister.sv
src/controlUnit.sv
tests/controlUnitTb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      := controlUnitTb
FILELIST := controlUnit.f

BIN      := obj_dir/V$(TOP)
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
